/* list.f */
rtl/board_pkg.sv
rtl/key_debounce.sv
rtl/reset_pulse_stretch.sv
rtl/led_heartbeat.sv
rtl/db25_header_map.sv
rtl/de0_nano_support.sv
test/tb_de0_nano_support.sv

/* Makefile */
# Verilator build and run for the board support testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_de0_nano_support
FILELIST  = list.f
LOG       = sim.log
PASS_LINE = No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_LINE)$$" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_de0_nano_support.sv */
// testbench for the board support top covering header map, key debounce, reset stretchers and heartbeat
`timescale 1ns/1ns

module tb_de0_nano_support;

	localparam int io_w       = board_pkg::io_width;     // widest value compared
	localparam int gpio_w     = board_pkg::gpio_width;
	localparam int blink_max  = 9;
	localparam int max_cycles = 3000;   // tests need about 700

	logic                                  fpga_clk_50;
	logic                                  arst_n;
	logic [board_pkg::key_count-1:0]       key;
	logic [board_pkg::reset_req_count-1:0] reset_req;
	logic [io_w-1:0]                       hm2_iobits;
	logic [board_pkg::led_count-1:0]       hm2_leds;
	logic [board_pkg::key_count-1:0]       key_db;
	logic                                  cold_reset;
	logic                                  warm_reset;
	logic                                  debug_reset;
	logic                                  led_heartbeat;
	logic [gpio_w-1:0]                     gpio_0;
	logic [gpio_w-1:0]                     gpio_1;

	logic [15:0]       lfsr;
	logic [gpio_w-1:0] exp_0;
	logic [gpio_w-1:0] exp_1;
	logic              hdr_armed = 1'b0;   // set after the first edge
	int                err_count = 0;
	int                check_count = 0;
	int                test_count = 0;
	int                test_errs = 0;      // err_count at start of current test
	int                cycle = 0;

	de0_nano_support #(
		.debounce_timeout (8),
		.blink_count_max  (blink_max)
	) de0_nano_support_i (
		.fpga_clk_50   (fpga_clk_50),
		.arst_n        (arst_n),
		.key           (key),
		.reset_req     (reset_req),
		.hm2_iobits    (hm2_iobits),
		.hm2_leds      (hm2_leds),
		.key_db        (key_db),
		.cold_reset    (cold_reset),
		.warm_reset    (warm_reset),
		.debug_reset   (debug_reset),
		.led_heartbeat (led_heartbeat),
		.gpio_0        (gpio_0),
		.gpio_1        (gpio_1)
	);

	initial begin
		fpga_clk_50 = 1'b0;
		forever #20 fpga_clk_50 = ~fpga_clk_50;   // 40 ns period
	end

	// ==============================
	// helpers
	// ==============================
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [io_w-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[io_w-2:0], lfsr[0]};   // one step per bit
		end
	endtask

	// DB25 adaptor pin order for one header
	function automatic logic [gpio_w-1:0] ref_header(input logic [33:0] io, input logic [1:0] led);
		logic [gpio_w-1:0] pins;
		pins = '0;
		for (int k = 0; k < 34; k++) begin
			if (k < 17)
				pins[(k % 2 == 0) ? 16 - k : 18 - k] = io[k];
			else
				pins[((k - 17) % 2 == 0) ? 34 - (k - 17) : 36 - (k - 17)] = io[k];
		end
		pins[1]  = led[0];
		pins[19] = led[1];
		return pins;
	endfunction

	task automatic compare(input logic [io_w-1:0] act, input logic [io_w-1:0] exp, input string msg);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %0t ns: %s, got %h expected %h", $time, msg, act, exp);
		end
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %-12s done, %0d errors", name, err_count - test_errs);
		test_errs = err_count;
	endtask

	function automatic logic stretch_out(input int idx);
		case (idx)
			0:       return cold_reset;
			1:       return warm_reset;
			default: return debug_reset;
		endcase
	endfunction

	// ==============================
	// comparing process
	// ==============================
	// headers trail their inputs by one edge
	always @(posedge fpga_clk_50) begin
		if (hdr_armed) begin
			compare(io_w'(gpio_0), io_w'(exp_0), "gpio_0 image");
			compare(io_w'(gpio_1), io_w'(exp_1), "gpio_1 image");
		end
		if (arst_n) begin
			exp_0 = ref_header(hm2_iobits[33:0], hm2_leds[1:0]);    // header 0
			exp_1 = ref_header(hm2_iobits[67:34], hm2_leds[3:2]);   // header 1
		end else begin
			exp_0 = '0;   // flops held in reset
			exp_1 = '0;
		end
		hdr_armed = 1'b1;
	end

	always @(posedge fpga_clk_50) begin
		cycle++;
		if (cycle >= max_cycles) begin
			$display("Timeout: the run was still going after %0d cycles", max_cycles);
			$display("Errors found");
			$finish;
		end
	end

	// ==============================
	// tests
	// ==============================
	task automatic check_heartbeat();
		logic exp_led;
		for (int c = 0; c <= 60; c++) begin
			if (c > 0)
				@(posedge fpga_clk_50);
			// low for blink_max+1 cycles after release and toggling each period after that
			exp_led = (c == 0) ? 1'b0 : 1'(((c - 1) / (blink_max + 1)) % 2);
			compare(io_w'(led_heartbeat), io_w'(exp_led), "heartbeat level");
		end
	endtask

	task automatic drive_header_traffic();
		logic [io_w-1:0] r;
		for (int n = 0; n < 200; n++) begin
			@(posedge fpga_clk_50);
			rand_bits(io_w, r);
			hm2_iobits <= r;
			rand_bits(board_pkg::led_count, r);
			hm2_leds <= r[board_pkg::led_count-1:0];
		end
		@(posedge fpga_clk_50);
		hm2_iobits <= '0;   // quiet headers
		hm2_leds   <= '0;
	endtask

	task automatic bounce_keys();
		logic [io_w-1:0] r;
		logic [1:0]      mask;
		int              glitch_len;
		for (int g = 0; g < 6; g++) begin
			rand_bits(3, r);
			glitch_len = (r[2:0] == 3'd0) ? 1 : int'(r[2:0]);   // 1 .. 7 cycles
			rand_bits(2, r);
			mask = (r[1:0] == 2'b00) ? 2'b11 : r[1:0];          // which keys bounce
			@(posedge fpga_clk_50);
			key <= ~mask;
			repeat (glitch_len) begin
				@(posedge fpga_clk_50);
				compare(io_w'(key_db), io_w'(2'b11), "key_db moved during glitch");
			end
			key <= 2'b11;
			repeat (12) begin
				@(posedge fpga_clk_50);
				compare(io_w'(key_db), io_w'(2'b11), "key_db moved after glitch");
			end
		end
		key <= 2'b10;   // key 0 held down
		repeat (20) @(posedge fpga_clk_50);
		compare(io_w'(key_db), io_w'(2'b10), "key_db after key 0 press");
		key <= 2'b01;   // key 1 held down, key 0 let go
		repeat (20) @(posedge fpga_clk_50);
		compare(io_w'(key_db), io_w'(2'b01), "key_db after key 1 press");
		key <= 2'b11;
		repeat (20) @(posedge fpga_clk_50);
		compare(io_w'(key_db), io_w'(2'b11), "key_db after release");
	endtask

	task automatic measure_pulse(input int idx, input int len, input bit second_edge,
			input string name);
		int   first_high;
		int   runs;
		int   run_len;
		logic now_q;
		logic prev_q;
		first_high = -1;
		runs       = 0;
		run_len    = 0;
		prev_q     = 1'b0;
		@(posedge fpga_clk_50);
		reset_req[idx] <= 1'b1;
		for (int s = 1; s <= 60; s++) begin
			@(posedge fpga_clk_50);
			if (s == 4)
				reset_req[idx] <= 1'b0;
			if (second_edge && s == 10)
				reset_req[idx] <= 1'b1;   // lands mid pulse
			if (second_edge && s == 14)
				reset_req[idx] <= 1'b0;
			now_q = stretch_out(idx);
			if (now_q && !prev_q) begin
				runs++;
				if (first_high < 0)
					first_high = s;
			end
			if (now_q)
				run_len++;
			prev_q = now_q;
		end
		compare(io_w'(runs), io_w'(1), {name, " high runs"});
		compare(io_w'(run_len), io_w'(len), {name, " pulse length"});
		// sampled one edge after the output flop sets so 3 cycles reads as 4
		compare(io_w'(first_high >= 1 && first_high <= 4), io_w'(1), {name, " pulse start"});
	endtask

	initial begin
		arst_n     = 1'b0;
		key        = '1;   // released
		reset_req  = '0;
		hm2_iobits = '0;
		hm2_leds   = '0;
		lfsr       = 16'd7536;
		repeat (2) @(posedge fpga_clk_50);
		arst_n <= 1'b1;
		// values left by reset
		compare(io_w'(gpio_0), '0, "gpio_0 after reset");
		compare(io_w'(gpio_1), '0, "gpio_1 after reset");
		compare(io_w'(key_db), io_w'(2'b11), "key_db after reset");

		check_heartbeat();
		finish_test("heartbeat");
		drive_header_traffic();
		finish_test("header_map");
		bounce_keys();
		finish_test("debounce");
		measure_pulse(0, board_pkg::cold_pulse_len, 1'b0, "cold");
		measure_pulse(1, board_pkg::warm_pulse_len, 1'b0, "warm");
		measure_pulse(2, board_pkg::debug_pulse_len, 1'b0, "debug");
		finish_test("pulse_len");
		measure_pulse(2, board_pkg::debug_pulse_len, 1'b1, "debug busy");
		finish_test("busy_ignore");

		repeat (2) @(posedge fpga_clk_50);
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* rtl/de0_nano_support.sv */
// DE0-Nano-SoC board support top, keys, reset stretchers, heartbeat and header mapping
`timescale 1ns/1ns

module de0_nano_support #(
	parameter int debounce_timeout = board_pkg::debounce_timeout_default,
	parameter int blink_count_max  = board_pkg::blink_count_max_default
) (
	input  logic                                  fpga_clk_50,
	input  logic                                  arst_n,
	input  logic [board_pkg::key_count-1:0]       key,          // low when pressed
	input  logic [board_pkg::reset_req_count-1:0] reset_req,    // cold, warm, debug
	input  logic [board_pkg::io_width-1:0]        hm2_iobits,   // from motion core
	input  logic [board_pkg::led_count-1:0]       hm2_leds,
	output logic [board_pkg::key_count-1:0]       key_db,
	output logic                                  cold_reset,
	output logic                                  warm_reset,
	output logic                                  debug_reset,
	output logic                                  led_heartbeat,
	output logic [board_pkg::gpio_width-1:0]      gpio_0,
	output logic [board_pkg::gpio_width-1:0]      gpio_1
);

	// ==============================
	// push keys
	// ==============================
	key_debounce #(
		.debounce_timeout (debounce_timeout)
	) key_debounce_i (
		.fpga_clk_50 (fpga_clk_50),
		.arst_n      (arst_n),
		.key         (key),
		.key_db      (key_db)
	);

	// ==============================
	// reset requests
	// ==============================
	reset_pulse_stretch #(
		.pulse_len (board_pkg::cold_pulse_len)
	) pulse_cold_i (
		.fpga_clk_50 (fpga_clk_50),
		.arst_n      (arst_n),
		.req         (reset_req[0]),
		.pulse       (cold_reset)
	);

	reset_pulse_stretch #(
		.pulse_len (board_pkg::warm_pulse_len)
	) pulse_warm_i (
		.fpga_clk_50 (fpga_clk_50),
		.arst_n      (arst_n),
		.req         (reset_req[1]),
		.pulse       (warm_reset)
	);

	reset_pulse_stretch #(
		.pulse_len (board_pkg::debug_pulse_len)   // longest, 32 cycles
	) pulse_debug_i (
		.fpga_clk_50 (fpga_clk_50),
		.arst_n      (arst_n),
		.req         (reset_req[2]),
		.pulse       (debug_reset)
	);

	// heartbeat
	led_heartbeat #(
		.blink_count_max (blink_count_max)
	) led_heartbeat_i (
		.fpga_clk_50 (fpga_clk_50),
		.arst_n      (arst_n),
		.led         (led_heartbeat)
	);

	// core io onto the two headers
	db25_header_map db25_header_map_i (
		.fpga_clk_50 (fpga_clk_50),
		.arst_n      (arst_n),
		.iobits      (hm2_iobits),
		.leds        (hm2_leds),
		.gpio_0      (gpio_0),
		.gpio_1      (gpio_1)
	);

endmodule

/* rtl/db25_header_map.sv */
// GPIO output stage, places core io bits and leds on both headers in DB25 adaptor order
`timescale 1ns/1ns

module db25_header_map (
	input  logic                             fpga_clk_50,
	input  logic                             arst_n,
	input  logic [board_pkg::io_width-1:0]   iobits,
	input  logic [board_pkg::led_count-1:0]  leds,
	output logic [board_pkg::gpio_width-1:0] gpio_0,
	output logic [board_pkg::gpio_width-1:0] gpio_1
);

	localparam int half = board_pkg::hdr_io_width / 2;   // 17 bits per DB25 row pair

	logic [board_pkg::gpio_width-1:0] hdr_q [board_pkg::num_headers];   // output flops

	for (genvar h = 0; h < board_pkg::num_headers; h++) begin : g_hdr
		logic [board_pkg::hdr_io_width-1:0]  hdr_io;
		logic [board_pkg::hdr_led_width-1:0] hdr_led;
		logic [board_pkg::gpio_width-1:0]    img;      // unregistered image

		assign hdr_io  = iobits[h*board_pkg::hdr_io_width +: board_pkg::hdr_io_width];
		assign hdr_led = leds[h*board_pkg::hdr_led_width +: board_pkg::hdr_led_width];

		// pins pair up as db25 1/14, 2/15 ... walking down the header
		always_comb begin
			img = '0;
			for (int k = 0; k < half; k++) begin
				if (k % 2 == 0)
					img[half - 1 - k] = hdr_io[k];          // 16, 14 .. 0
				else
					img[half + 1 - k] = hdr_io[k];          // 17, 15 .. 3
			end
			// second connector on the upper pins
			for (int j = 0; j < half; j++) begin
				if (j % 2 == 0)
					img[2*half - j] = hdr_io[half + j];     // 34, 32 .. 18
				else
					img[2*half + 2 - j] = hdr_io[half + j]; // 35, 33 .. 21
			end
			img[1]        = hdr_led[0];   // spare pin, lower half
			img[half + 2] = hdr_led[1];   // pin 19
		end

		always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
			if (!arst_n)
				hdr_q[h] <= '0;
			else
				hdr_q[h] <= img;
		end

		// led pins trail their inputs by one clock
		a_led_pins: assert property (
			@(posedge fpga_clk_50) disable iff (!arst_n)
			$past(arst_n) |->
				(hdr_q[h][1] == $past(leds[h*board_pkg::hdr_led_width])) &&
				(hdr_q[h][half + 2] == $past(leds[h*board_pkg::hdr_led_width + 1]))
		);
	end

	assign gpio_0 = hdr_q[0];
	assign gpio_1 = hdr_q[1];

endmodule

/* rtl/led_heartbeat.sv */
// heartbeat blinker, free-running counter toggling one LED
`timescale 1ns/1ns

module led_heartbeat #(
	parameter int blink_count_max = board_pkg::blink_count_max_default
) (
	input  logic fpga_clk_50,
	input  logic arst_n,
	output logic led        // toggles every blink_count_max+1 cycles
);

	localparam int cnt_w = (blink_count_max > 0) ? $clog2(blink_count_max + 1) : 1;
	localparam logic [cnt_w-1:0] cnt_wrap = cnt_w'(blink_count_max);

	logic [cnt_w-1:0] cnt;

	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			led <= 1'b0;           // starts dark
		end else if (cnt == cnt_wrap) begin
			cnt <= '0;             // wrap
			led <= ~led;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

/* rtl/reset_pulse_stretch.sv */
// reset request stretcher, rising edge in, fixed length pulse out
`timescale 1ns/1ns

module reset_pulse_stretch #(
	parameter int pulse_len = board_pkg::cold_pulse_len
) (
	input  logic fpga_clk_50,
	input  logic arst_n,
	input  logic req,      // async request level
	output logic pulse     // high for pulse_len cycles
);

	localparam int cnt_w = (pulse_len > 1) ? $clog2(pulse_len) : 1;
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(pulse_len - 1);

	logic req_meta;
	logic req_sync;
	logic req_q;        // last synced value, for edge detect
	logic rise;

	board_pkg::pulse_state_e state;
	logic [cnt_w-1:0]        cnt;     // cycles spent busy

	// ==============================
	// sync and edge detect
	// ==============================
	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			req_meta <= 1'b0;
			req_sync <= 1'b0;
			req_q    <= 1'b0;
		end else begin
			req_meta <= req;
			req_sync <= req_meta;
			req_q    <= req_sync;
		end
	end

	assign rise = req_sync & ~req_q;

	// ==============================
	// stretch fsm
	// ==============================
	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= board_pkg::pulse_idle;
			cnt   <= '0;
			pulse <= 1'b0;
		end else begin
			case (state)
				board_pkg::pulse_idle: begin
					if (rise) begin
						state <= board_pkg::pulse_busy;
						cnt   <= '0;
						pulse <= 1'b1;
					end
				end
				board_pkg::pulse_busy: begin
					// edges in here are dropped
					if (cnt == cnt_last) begin
						state <= board_pkg::pulse_idle;
						pulse <= 1'b0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					state <= board_pkg::pulse_idle;
					pulse <= 1'b0;
				end
			endcase
		end
	end

	a_pulse_state: assert property (
		@(posedge fpga_clk_50) disable iff (!arst_n)
		pulse == (state == board_pkg::pulse_busy)
	);

	// one busy run is exactly pulse_len cycles
	a_pulse_len: assert property (
		@(posedge fpga_clk_50) disable iff (!arst_n)
		$rose(state == board_pkg::pulse_busy) |->
			(state == board_pkg::pulse_busy) [*pulse_len] ##1 (state == board_pkg::pulse_idle)
	);

endmodule

/* rtl/key_debounce.sv */
// key debouncer, two-flop synchronizer and a stable counter per key
`timescale 1ns/1ns

module key_debounce #(
	parameter int debounce_timeout = board_pkg::debounce_timeout_default
) (
	input  logic                            fpga_clk_50,
	input  logic                            arst_n,
	input  logic [board_pkg::key_count-1:0] key,      // raw pins, low when pressed
	output logic [board_pkg::key_count-1:0] key_db    // settled level
);

	// counter runs 0 .. debounce_timeout-1
	localparam int cnt_w = (debounce_timeout > 1) ? $clog2(debounce_timeout) : 1;
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_timeout - 1);

	logic [board_pkg::key_count-1:0] key_meta;   // first sync stage
	logic [board_pkg::key_count-1:0] key_sync;   // safe to use
	logic [board_pkg::key_count-1:0] cnt_done;   // per-key expiry

	// keys idle high, so sync stages reset to released
	always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			key_meta <= '1;
			key_sync <= '1;
		end else begin
			key_meta <= key;
			key_sync <= key_meta;
		end
	end

	for (genvar i = 0; i < board_pkg::key_count; i++) begin : g_key
		logic [cnt_w-1:0] cnt;   // cycles the new level has held

		assign cnt_done[i] = (cnt == cnt_last);

		always_ff @(posedge fpga_clk_50 or negedge arst_n) begin
			if (!arst_n) begin
				cnt       <= '0;
				key_db[i] <= 1'b1;           // released
			end else if (key_sync[i] == key_db[i]) begin
				cnt <= '0;                   // bounce back, start over
			end else if (cnt_done[i]) begin
				cnt       <= '0;
				key_db[i] <= key_sync[i];    // level held long enough
			end else begin
				cnt <= cnt + 1'b1;
			end
		end

		// output only moves after a full run of differing samples
		a_db_hold: assert property (
			@(posedge fpga_clk_50) disable iff (!arst_n)
			$changed(key_db[i]) |-> $past(cnt_done[i] && (key_sync[i] != key_db[i]))
		);
	end

endmodule

/* rtl/board_pkg.sv */
// board support package for DE0-Nano-SoC header geometry, timing and shared types
package board_pkg;

	// ==============================
	// header geometry
	// ==============================
	localparam int gpio_width    = 36;   // pins per 2x20 header
	localparam int num_headers   = 2;    // gpio_0 and gpio_1
	localparam int hdr_io_width  = 34;   // core io bits per header
	localparam int hdr_led_width = 2;    // core leds per header

	// totals across both headers
	localparam int io_width  = num_headers * hdr_io_width;    // 68
	localparam int led_count = num_headers * hdr_led_width;   // 4

	// ==============================
	// board inputs
	// ==============================
	localparam int key_count       = 2;   // KEY[1:0], active low
	localparam int reset_req_count = 3;   // cold, warm, debug

	// ==============================
	// timing defaults, 50 MHz clock
	// ==============================
	localparam int cold_pulse_len  = 6;    // cycles
	localparam int warm_pulse_len  = 2;
	localparam int debug_pulse_len = 32;

	// 1 ms settle time on the keys
	localparam int debounce_timeout_default = 50000;

	// half period of a 1 Hz blink
	localparam int blink_count_max_default = 24999999;

	// reset stretcher fsm
	typedef enum logic {
		pulse_idle,   // waiting for a rising edge
		pulse_busy    // output held high
	} pulse_state_e;

endpackage
